// ==== adc_snap_defs.svh ====
// Sizing and register map of the ADC snapshot block.
// The window decode takes the channel from address bits 9:8, so it
// assumes four channels of 64 words each.
// Register offsets are word indices, the window base is a byte offset.

`ifndef ADC_SNAP_DEFS_SVH
`define ADC_SNAP_DEFS_SVH

// number of ADC channels captured in parallel
`define ADC_SNAP_NUM_CH 4

// snapshot address width, one address per 32-bit sample word
`define ADC_SNAP_AW 6

// words written per channel during one capture
`define ADC_SNAP_DEPTH 64

// control register, bit 0 is snap_req
`define ADC_SNAP_REG_CTRL 0

// status register, bit 0 done, bit 1 busy
`define ADC_SNAP_REG_STAT 1

// buffer window, channel c word k at base + c*0x100 + 4*k
`define ADC_SNAP_WIN_BASE 32'h0000_0400

`endif

// ==== adc_snap_pkg.sv ====
// Types shared by the snapshot controller, buffers and register block.
// A sample word packs four 8-bit ADC samples.

`include "adc_snap_defs.svh"

package adc_snap_pkg;

  typedef logic [31:0] sample_t;                           // four packed 8-bit samples

  typedef logic [`ADC_SNAP_AW-1:0] snap_addr_t;             // buffer word address

  typedef logic [`ADC_SNAP_AW:0] snap_cnt_t;                // msb set means capture over

  typedef logic [$clog2(`ADC_SNAP_NUM_CH)-1:0] chan_t;      // channel index

  typedef logic [31:0] wb_word_t;                          // bus data

  typedef logic [31:0] wb_adr_t;                           // bus byte address

  // capture controller states
  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_RUN,
    CAP_DONE
  } cap_state_t;

endpackage

// ==== adc_snap_top.sv ====
// Four-channel ADC snapshot capture with a Wishbone register interface.
// Bus and sampling logic both run on user_clk.
// adc_data_i holds one sample_t per channel, channel 0 in the low word.
// Capture starts on the falling edge of control bit 0; poll status for done.

`timescale 1ns/1ps
`include "adc_snap_defs.svh"

module adc_snap_top
  import adc_snap_pkg::*;
(
  input  logic                                       user_clk,
  input  logic                                       rst,
  input  logic                                       wb_cyc_i,
  input  logic                                       wb_stb_i,
  input  logic                                       wb_we_i,
  input  wb_adr_t                                    wb_adr_i,
  input  logic [3:0]                                 wb_sel_i,
  input  wb_word_t                                   wb_dat_i,
  output wb_word_t                                   wb_dat_o,
  output logic                                       wb_ack_o,
  input  logic [`ADC_SNAP_NUM_CH*$bits(sample_t)-1:0] adc_data_i
);

  logic                           snap_req;
  logic                           snap_we;
  snap_addr_t                     snap_addr;
  logic                           cap_busy;
  logic                           cap_done;
  logic                           buf_rd_en;
  snap_addr_t                     buf_rd_addr;
  sample_t [`ADC_SNAP_NUM_CH-1:0] buf_rd_data;

  snap_capture_ctrl u_ctrl (
    .user_clk    (user_clk),
    .rst         (rst),
    .snap_req_i  (snap_req),
    .snap_we_o   (snap_we),
    .snap_addr_o (snap_addr),
    .cap_busy_o  (cap_busy),
    .cap_done_o  (cap_done)
  );

  // every channel writes the same address on the same cycle
  for (genvar c = 0; c < `ADC_SNAP_NUM_CH; c++)
  begin : g_buf
    snap_buffer u_buf (
      .user_clk  (user_clk),
      .we_i      (snap_we),
      .wr_addr_i (snap_addr),
      .wr_data_i (adc_data_i[c*$bits(sample_t) +: $bits(sample_t)]),
      .rd_en_i   (buf_rd_en),
      .rd_addr_i (buf_rd_addr),
      .rd_data_o (buf_rd_data[c])
    );
  end

  wb_snap_regs u_regs (
    .user_clk      (user_clk),
    .rst           (rst),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_sel_i      (wb_sel_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .cap_busy_i    (cap_busy),
    .cap_done_i    (cap_done),
    .snap_req_o    (snap_req),
    .buf_rd_en_o   (buf_rd_en),
    .buf_rd_addr_o (buf_rd_addr),
    .buf_rd_data_i (buf_rd_data)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the snapshot testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_adc_snap -o sim_adc_snap > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

{ ./obj_dir/sim_adc_snap > sim.log 2>&1 || true; }

cat sim.log

grep -qF '*** PASSED ***' sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== snap_buffer.sv ====
// Snapshot memory for one ADC channel, DEPTH words of one sample_t each.
// One write port, one read port with a registered output held while
// rd_en_i is low. Contents are undefined until the first capture.

`timescale 1ns/1ps
`include "adc_snap_defs.svh"

module snap_buffer
  import adc_snap_pkg::*;
(
  input  logic       user_clk,
  input  logic       we_i,
  input  snap_addr_t wr_addr_i,
  input  sample_t    wr_data_i,
  input  logic       rd_en_i,
  input  snap_addr_t rd_addr_i,
  output sample_t    rd_data_o
);

  sample_t mem [`ADC_SNAP_DEPTH];                          // maps to block RAM
  sample_t rd_q;

  // capture side, one word per cycle while the strobe is high
  always_ff @(posedge user_clk)
  begin
    if (we_i)
      mem[wr_addr_i] <= wr_data_i;
  end

  // readback side
  always_ff @(posedge user_clk)
  begin
    if (rd_en_i)
      rd_q <= mem[rd_addr_i];                              // old data on a same-address collision
  end

  assign rd_data_o = rd_q;

endmodule

// ==== snap_capture_ctrl.sv ====
// Snapshot write sequencer. A falling edge on snap_req_i starts one pass
// of DEPTH consecutive writes; a new edge mid-capture restarts at 0.
// snap_req_i must already be in the user_clk domain.
// After reset the counter is parked, so nothing is written until a request.

`timescale 1ns/1ps
`include "adc_snap_defs.svh"

module snap_capture_ctrl
  import adc_snap_pkg::*;
(
  input  logic       user_clk,
  input  logic       rst,
  input  logic       snap_req_i,
  output logic       snap_we_o,
  output snap_addr_t snap_addr_o,
  output logic       cap_busy_o,
  output logic       cap_done_o
);

  localparam snap_cnt_t cnt_park = snap_cnt_t'(`ADC_SNAP_DEPTH);   // terminal count
  localparam snap_cnt_t cnt_last = snap_cnt_t'(`ADC_SNAP_DEPTH - 1);

  logic [1:0] req_sr;                                      // previous and current request
  logic       req_fall;
  snap_cnt_t  cap_cnt;
  cap_state_t cap_state;

  always_ff @(posedge user_clk)
  begin
    if (rst)
      req_sr <= 2'b00;
    else
      req_sr <= {req_sr[0], snap_req_i};
  end

  assign req_fall = (req_sr == 2'b10);                     // was set, now cleared

  always_ff @(posedge user_clk)
  begin
    if (rst)
      cap_cnt <= cnt_park;
    else if (req_fall)
      cap_cnt <= '0;                                       // start or restart
    else if (!cap_cnt[`ADC_SNAP_AW])
      cap_cnt <= cap_cnt + 1'b1;
  end

  assign snap_we_o   = ~cap_cnt[`ADC_SNAP_AW];
  assign snap_addr_o = cap_cnt[`ADC_SNAP_AW-1:0];

  // status tracking, RUN lines up with the write strobe
  always_ff @(posedge user_clk)
  begin
    if (rst)
      cap_state <= CAP_IDLE;
    else if (req_fall)
      cap_state <= CAP_RUN;
    else if (cap_state == CAP_RUN && cap_cnt == cnt_last)
      cap_state <= CAP_DONE;                               // last word written this cycle
  end

  assign cap_busy_o = (cap_state == CAP_RUN);
  assign cap_done_o = (cap_state == CAP_DONE);

  // the strobe only runs inside the buffer range and only while the FSM is in RUN
  a_we_in_range: assert property (@(posedge user_clk) disable iff (rst)
    snap_we_o |-> (cap_cnt < cnt_park) && (cap_state == CAP_RUN));

  a_busy_done_excl: assert property (@(posedge user_clk) disable iff (rst)
    !(cap_busy_o && cap_done_o));

endmodule

// ==== snap_stim.txt ====
// columns: cmd addr data sel, cmd is ASCII hex (57 W, 52 R, 50 P, 43 C, 51 Q)
// W addr data sel | R addr expected | C channel newer | P and Q ignore the fields
// after reset
52 00000000 00000000 0
52 00000004 00000000 0
// byte lanes with bit 0 held low
57 00000000 a5a5a5a4 f
57 00000000 12345678 6
52 00000000 a53456a4 0
52 00000004 00000000 0
57 00000000 00000000 f
// first capture
57 00000000 00000001 1
57 00000000 00000000 1
50 00000000 00000000 0
52 00000004 00000001 0
43 00000000 00000000 0
43 00000001 00000000 0
43 00000002 00000000 0
43 00000003 00000000 0
// recapture, start must be past the previous end
57 00000000 00000001 1
57 00000000 00000000 1
50 00000000 00000000 0
52 00000004 00000001 0
43 00000000 00000001 0
43 00000001 00000001 0
43 00000002 00000001 0
43 00000003 00000001 0
// set without clear, no capture
57 00000000 00000001 1
52 00000004 00000001 0
52 00000000 00000001 0
52 00000004 00000001 0
51 00000000 00000000 0

// ==== tb_adc_snap.sv ====
// Testbench for the ADC snapshot block, driven from snap_stim.txt.
// Each stimulus record is an ASCII command word followed by three hex fields.
// The ADC source is a free-running ramp, channel number in the top byte.
// Stops at the first mismatch or timeout.

`timescale 1ns/1ps
`include "adc_snap_defs.svh"

module tb_adc_snap
  import adc_snap_pkg::*;
;

  localparam int stim_words = 256;                         // room for 64 commands
  localparam int ack_limit  = 20;                          // cycles to wait for wb_ack_o
  localparam int poll_limit = 100;                         // status reads before giving up

  logic                                        user_clk = 1'b0;
  logic                                        rst;
  logic                                        wb_cyc;
  logic                                        wb_stb;
  logic                                        wb_we;
  wb_adr_t                                     wb_adr;
  logic [3:0]                                  wb_sel;
  wb_word_t                                    wb_dat_w;
  wb_word_t                                    wb_dat_r;
  logic                                        wb_ack;
  logic [`ADC_SNAP_NUM_CH*$bits(sample_t)-1:0] adc_data = '0;
  logic [23:0]                                 ramp = '0;

  logic [31:0] stim_mem [stim_words];
  logic [23:0] last_word [`ADC_SNAP_NUM_CH];                // end of the previous capture

  adc_snap_top dut (
    .user_clk   (user_clk),
    .rst        (rst),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_sel_i   (wb_sel),
    .wb_dat_i   (wb_dat_w),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .adc_data_i (adc_data)
  );

  always #5 user_clk = ~user_clk;

  // free-running ramp shared by every channel
  always @(posedge user_clk)
  begin
    ramp <= ramp + 24'd1;
    for (int c = 0; c < `ADC_SNAP_NUM_CH; c++)
      adc_data[c*32 +: 32] <= {8'(c), ramp};
  end

  task automatic report_mismatch(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "stopping at first mismatch");
  endtask

  task automatic report_abort(input string msg);
    $display("at time %0t the run cannot go on: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(input wb_word_t got, input wb_word_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_sample(input sample_t got, input chan_t exp_ch,
                              input logic [23:0] exp_val, input string what);
    sample_t exp;
    exp = {8'(exp_ch), exp_val};                           // tag byte over the ramp value
    if (got !== exp)
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp)
      report_mismatch($sformatf("%s got %0d cycles expected %0d", what, got, exp));
  endtask

  task automatic idle_gap();
    repeat ($urandom % 4) @(posedge user_clk);
  endtask

  // single-beat cycle with the request held until ack
  task automatic bus_access(input logic we, input wb_adr_t adr, input wb_word_t dat,
                            input logic [3:0] sel, output wb_word_t rdata);
    int waited;
    int exp_lat;
    waited  = 0;
    exp_lat = (!we && adr >= `ADC_SNAP_WIN_BASE &&
               adr < `ADC_SNAP_WIN_BASE + `ADC_SNAP_NUM_CH * 32'h100) ? 2 : 1;
    @(posedge user_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_sel   <= sel;
    wb_dat_w <= dat;
    @(negedge user_clk);
    while (!wb_ack)
    begin
      if (waited >= ack_limit)
        report_abort($sformatf("no bus acknowledge for address %h", adr));
      waited++;
      @(negedge user_clk);
    end
    rdata = wb_dat_r;                                      // sampled mid-cycle where it is settled
    check_latency(waited, exp_lat, $sformatf("ack latency for address %h", adr));
    @(posedge user_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic poll_done();
    wb_word_t st;
    int       polls;
    st    = '0;
    polls = 0;
    while (!st[0])
    begin
      if (polls >= poll_limit)
        report_abort("status done bit never came up while polling");
      bus_access(1'b0, wb_adr_t'(`ADC_SNAP_REG_STAT * 4), '0, 4'hf, st);
      polls++;
    end
  endtask

  // word 0 gives the ramp start and every later word follows it by one
  task automatic check_buffer(input chan_t ch, input logic newer);
    wb_adr_t     base;
    wb_word_t    rd;
    logic [23:0] start;
    base = `ADC_SNAP_WIN_BASE + wb_adr_t'(ch) * 32'h100;
    bus_access(1'b0, base, '0, 4'hf, rd);
    start = rd[23:0];
    check_sample(rd, ch, start, $sformatf("channel %0d word 0", ch));
    if (newer && start <= last_word[ch])
      report_mismatch($sformatf("channel %0d recapture starts at %h, previous end %h",
                                ch, start, last_word[ch]));
    for (int k = 1; k < `ADC_SNAP_DEPTH; k++)
    begin
      bus_access(1'b0, base + wb_adr_t'(4 * k), '0, 4'hf, rd);
      check_sample(rd, ch, start + 24'(k), $sformatf("channel %0d word %0d", ch, k));
    end
    last_word[ch] = start + 24'(`ADC_SNAP_DEPTH - 1);
  endtask

  initial
  begin
    logic [7:0] op;
    wb_word_t   f0;
    wb_word_t   f1;
    wb_word_t   f2;
    wb_word_t   rd;
    logic       quit;
    void'($urandom(32'hae20d6fa));
    rst      <= 1'b1;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_sel   <= '0;
    wb_dat_w <= '0;
    quit = 1'b0;
    for (int c = 0; c < `ADC_SNAP_NUM_CH; c++)
      last_word[c] = '0;
    for (int i = 0; i < stim_words; i++)
      stim_mem[i] = '0;                                    // an empty record reads as op 0
    $readmemh("snap_stim.txt", stim_mem);
    repeat (2) @(posedge user_clk);
    rst <= 1'b0;
    for (int i = 0; i < stim_words / 4 && !quit; i++)
    begin
      op = stim_mem[4*i][7:0];
      f0 = stim_mem[4*i+1];
      f1 = stim_mem[4*i+2];
      f2 = stim_mem[4*i+3];
      idle_gap();
      case (op)
        "W": bus_access(1'b1, f0, f1, f2[3:0], rd);
        "R":
        begin
          bus_access(1'b0, f0, '0, 4'hf, rd);
          check_word(rd, f1, $sformatf("read of %h", f0));
        end
        "P": poll_done();
        "C": check_buffer(f0[1:0], f1[0]);
        "Q": quit = 1'b1;
        default: report_abort($sformatf("unknown stimulus command %h in record %0d", op, i));
      endcase
    end
    if (!quit)
      report_abort("stimulus file ended without a Q command");
    else
      $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
adc_snap_pkg.sv
snap_capture_ctrl.sv
snap_buffer.sv
wb_snap_regs.sv
adc_snap_top.sv
tb_adc_snap.sv

// ==== wb_snap_regs.sv ====
// Wishbone slave for the snapshot block, single-beat cycles only.
// Register accesses ack after 1 cycle, buffer window reads after 2.
// Writes outside the control register are acked and dropped; there is
// no error response. Window reads during a capture return live memory.

`timescale 1ns/1ps
`include "adc_snap_defs.svh"

module wb_snap_regs
  import adc_snap_pkg::*;
(
  input  logic                              user_clk,
  input  logic                              rst,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  wb_adr_t                           wb_adr_i,
  input  logic [3:0]                        wb_sel_i,
  input  wb_word_t                          wb_dat_i,
  output wb_word_t                          wb_dat_o,
  output logic                              wb_ack_o,
  input  logic                              cap_busy_i,
  input  logic                              cap_done_i,
  output logic                              snap_req_o,
  output logic                              buf_rd_en_o,
  output snap_addr_t                        buf_rd_addr_o,
  input  sample_t [`ADC_SNAP_NUM_CH-1:0]    buf_rd_data_i
);

  localparam wb_adr_t win_base = `ADC_SNAP_WIN_BASE;

  wb_word_t   ctrl_reg;
  wb_word_t   dat_reg;                                     // register read data held for ack
  wb_word_t   reg_rdata;
  logic       ack;
  logic       ack_win;                                     // current ack belongs to a window read
  logic       rd_pend;                                     // waiting on buffer read latency
  chan_t      rd_ch;
  logic       req;
  logic       win_hit;
  logic       reg_hit;
  logic       ctrl_hit;
  logic       stat_hit;
  logic [7:0] reg_idx;

  // a new request is taken only when nothing is in flight
  assign req = wb_cyc_i && wb_stb_i && !ack && !rd_pend;

  assign win_hit  = (wb_adr_i[31:10] == win_base[31:10]);
  assign reg_hit  = (wb_adr_i[31:10] == '0);
  assign reg_idx  = wb_adr_i[9:2];
  assign ctrl_hit = reg_hit && (reg_idx == 8'(`ADC_SNAP_REG_CTRL));
  assign stat_hit = reg_hit && (reg_idx == 8'(`ADC_SNAP_REG_STAT));

  always_comb
  begin
    reg_rdata = '0;                                        // unmapped addresses read zero
    if (ctrl_hit)
      reg_rdata = ctrl_reg;
    else if (stat_hit)
      reg_rdata = {30'b0, cap_busy_i, cap_done_i};
  end

  // handshake and control register
  always_ff @(posedge user_clk)
  begin
    if (rst)
    begin
      ack         <= 1'b0;
      rd_pend     <= 1'b0;
      buf_rd_en_o <= 1'b0;
      ctrl_reg    <= '0;
    end
    else
    begin
      ack         <= 1'b0;
      buf_rd_en_o <= 1'b0;
      if (rd_pend)
      begin
        rd_pend <= 1'b0;                                   // buffer output valid next cycle
        ack     <= 1'b1;
      end
      else if (req)
      begin
        if (win_hit && !wb_we_i)
        begin
          rd_pend     <= 1'b1;
          buf_rd_en_o <= 1'b1;
        end
        else
        begin
          ack <= 1'b1;
        end
        if (wb_we_i && ctrl_hit)
        begin
          for (int b = 0; b < 4; b++)
          begin
            if (wb_sel_i[b])
              ctrl_reg[8*b +: 8] <= wb_dat_i[8*b +: 8];    // byte lane write
          end
        end
      end
    end
  end

  // read payload, only looked at while ack is high
  always_ff @(posedge user_clk)
  begin
    if (req)
    begin
      ack_win       <= win_hit && !wb_we_i;
      buf_rd_addr_o <= wb_adr_i[`ADC_SNAP_AW+1:2];
      rd_ch         <= wb_adr_i[9:8];
      dat_reg       <= reg_rdata;
    end
  end

  assign wb_ack_o   = ack;
  assign snap_req_o = ctrl_reg[0];

  always_comb
  begin
    if (!ack)
      wb_dat_o = '0;
    else if (ack_win)
      wb_dat_o = buf_rd_data_i[rd_ch];                     // word from the selected channel
    else
      wb_dat_o = dat_reg;
  end

  a_ack_pulse: assert property (@(posedge user_clk) disable iff (rst)
    wb_ack_o |=> !wb_ack_o);

endmodule
